// File: Bender.yml
package:
  name: cpu

sources:
  - include_dirs:
      - include
    files:
      - source/isa_pkg.sv
      - source/pipe_pkg.sv
      - source/fetch_stage.sv
      - source/regfile.sv
      - source/decode_stage.sv
      - source/exec_stage.sv
      - source/mult_pipe.sv
      - source/cpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/cpu_properties.sv
      - verification/cpu_tb.sv

// File: files.f
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_stage.sv
source/regfile.sv
source/decode_stage.sv
source/exec_stage.sv
source/mult_pipe.sv
source/cpu.sv
verification/cpu_properties.sv
verification/cpu_tb.sv

// File: include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data word width
`define REG_SIZE 32
// Register index width
`define REG_ADDR 5
// Byte address width
`define ADDR_SIZE 32
// Architectural registers
`define REG_COUNT 32
// Multiplier depth
`define MULT_STAGES 5

`endif

// File: source/cpu.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module cpu (
   input  logic                  clk,
   input  logic                  if_id_reset,
   output logic [`ADDR_SIZE-1:0] imem_addr,
   input  isa_pkg::instr_u       imem_data,
   input  logic                  imem_valid,
   output pipe_pkg::wb_t         wb
);

   isa_pkg::instr_u       if_id_instr;
   logic [`ADDR_SIZE-1:0] if_id_pc;
   logic                  pc_write;
   pipe_pkg::stage_ctl_t  if_id_ctl;
   pipe_pkg::stage_ctl_t  id_ex_ctl;
   logic [`REG_ADDR-1:0]  rs1;
   logic [`REG_ADDR-1:0]  rs2;
   logic [`REG_SIZE-1:0]  rdata1;
   logic [`REG_SIZE-1:0]  rdata2;
   logic                  hazard_stall;
   pipe_pkg::id_ex_t      id_ex;
   pipe_pkg::wb_t         alu_wb;
   pipe_pkg::wb_t         mult_wb;
   pipe_pkg::wb_t         wb_next;
   logic [`REG_COUNT-1:0] pending_mask;
   logic                  branch_taken;
   logic [`ADDR_SIZE-1:0] branch_target;

   fetch_stage fetch_inst (
      .clk          (clk),
      .if_id_reset  (if_id_reset),
      .pc_write     (pc_write),
      .branch_taken (branch_taken),
      .branch_target(branch_target),
      .pc           (imem_addr)
   );

   // Stall and flush priority
   always_comb begin
      pc_write  = 1'b1;
      if_id_ctl = '{hold: 1'b0, flush: 1'b0};
      id_ex_ctl = '{hold: 1'b0, flush: 1'b0};
      if (if_id_reset) begin
         if_id_ctl.flush = 1'b1;
         id_ex_ctl.flush = 1'b1;
      end else if (branch_taken) begin
         if_id_ctl.flush = 1'b1;  // Squash both younger instructions
         id_ex_ctl.flush = 1'b1;
      end else if (hazard_stall) begin
         pc_write        = 1'b0;
         if_id_ctl.hold  = 1'b1;
         id_ex_ctl.flush = 1'b1;
      end else if (!imem_valid) begin
         pc_write        = 1'b0;
         if_id_ctl.flush = 1'b1;
      end
   end

   // Flush loads the zero word, which decodes as a bubble
   always_ff @(posedge clk) begin
      if (if_id_ctl.flush) begin
         if_id_instr <= '0;
      end else if (!if_id_ctl.hold) begin
         if_id_instr <= imem_data;
         if_id_pc    <= imem_addr;
      end
   end

   regfile regfile_inst (
      .clk   (clk),
      .rs1   (rs1),
      .rs2   (rs2),
      .wr    (wb),
      .rdata1(rdata1),
      .rdata2(rdata2)
   );

   decode_stage decode_inst (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .instr       (if_id_instr),
      .pc          (if_id_pc),
      .rdata1      (rdata1),
      .rdata2      (rdata2),
      .ctl         (id_ex_ctl),
      .wb_pending  (alu_wb),
      .pending_mask(pending_mask),
      .rs1         (rs1),
      .rs2         (rs2),
      .hazard_stall(hazard_stall),
      .id_ex       (id_ex)
   );

   exec_stage exec_inst (
      .clk          (clk),
      .if_id_reset  (if_id_reset),
      .id_ex        (id_ex),
      .flush        (if_id_reset),  // Stale entry issues nothing during reset
      .alu_wb       (alu_wb),
      .branch_taken (branch_taken),
      .branch_target(branch_target)
   );

   mult_pipe mult_inst (
      .clk         (clk),
      .if_id_reset (if_id_reset),
      .id_ex       (id_ex),
      .mult_wb     (mult_wb),
      .pending_mask(pending_mask)
   );

   // Decode keeps at most one source valid per cycle
   assign wb_next = (alu_wb & {$bits(pipe_pkg::wb_t){alu_wb.valid}})
                  | (mult_wb & {$bits(pipe_pkg::wb_t){mult_wb.valid}});

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         wb.valid <= 1'b0;
      end else begin
         wb <= wb_next;
      end
   end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module decode_stage (
   input  logic                  clk,
   input  logic                  if_id_reset,
   input  isa_pkg::instr_u       instr,
   input  logic [`ADDR_SIZE-1:0] pc,
   input  logic [`REG_SIZE-1:0]  rdata1,
   input  logic [`REG_SIZE-1:0]  rdata2,
   input  pipe_pkg::stage_ctl_t  ctl,
   input  pipe_pkg::wb_t         wb_pending,
   input  logic [`REG_COUNT-1:0] pending_mask,
   output logic [`REG_ADDR-1:0]  rs1,
   output logic [`REG_ADDR-1:0]  rs2,
   output logic                  hazard_stall,
   output pipe_pkg::id_ex_t      id_ex
);

   pipe_pkg::id_ex_t dec;
   logic             uses_rt;
   logic             alu_write;
   logic             mult_busy;

   // Source still owed by an older instruction
   function automatic logic busy(input logic [`REG_ADDR-1:0] src);
      logic hit;
      hit = 1'b0;
      if (src != '0) begin
         hit = (id_ex.valid && id_ex.regwrite && id_ex.dst == src)
            || (wb_pending.valid && wb_pending.dst == src)
            || pending_mask[src];
      end
      return hit;
   endfunction

   // Same bit positions in both formats
   assign rs1 = instr.r.rs;
   assign rs2 = instr.r.rt;

   always_comb begin
      dec        = '0;
      dec.pc     = pc;
      dec.src1   = rdata1;
      dec.src2   = rdata2;
      dec.imm    = instr.i.imm;
      dec.dst    = instr.r.rd;
      dec.alu_op = pipe_pkg::ALU_ADD;
      uses_rt    = 1'b0;
      case (instr.r.opcode)
         isa_pkg::OP_RTYPE: begin
            uses_rt      = 1'b1;
            dec.valid    = 1'b1;
            dec.regwrite = 1'b1;
            case (instr.r.funct)
               isa_pkg::FN_ADD: dec.alu_op = pipe_pkg::ALU_ADD;
               isa_pkg::FN_SUB: dec.alu_op = pipe_pkg::ALU_SUB;
               isa_pkg::FN_AND: dec.alu_op = pipe_pkg::ALU_AND;
               isa_pkg::FN_OR:  dec.alu_op = pipe_pkg::ALU_OR;
               isa_pkg::FN_SLT: dec.alu_op = pipe_pkg::ALU_SLT;
               isa_pkg::FN_MUL: dec.is_mult = 1'b1;
               default: begin
                  dec.valid    = 1'b0;  // Zero word lands here as a bubble
                  dec.regwrite = 1'b0;
               end
            endcase
         end
         isa_pkg::OP_ADDI: begin
            dec.valid    = 1'b1;
            dec.regwrite = 1'b1;
            dec.alusrc   = 1'b1;
            dec.dst      = instr.i.rt;
         end
         isa_pkg::OP_BEQ: begin
            uses_rt       = 1'b1;
            dec.valid     = 1'b1;
            dec.is_branch = 1'b1;
            dec.alu_op    = pipe_pkg::ALU_SUB;
         end
         default: ;
      endcase
      if (dec.dst == '0) begin
         dec.regwrite = 1'b0;
      end
   end

   // ALU writes must not overtake a multiply still in flight
   assign alu_write = dec.valid && dec.regwrite && !dec.is_mult;
   assign mult_busy = (pending_mask != '0) || (id_ex.valid && id_ex.is_mult && id_ex.regwrite);

   always_comb begin
      hazard_stall = dec.valid
         && (busy(rs1) || (uses_rt && busy(rs2)) || (alu_write && mult_busy));
   end

   always_ff @(posedge clk) begin
      if (if_id_reset || ctl.flush) begin
         id_ex.valid <= 1'b0;
      end else if (!ctl.hold) begin
         id_ex <= dec;
      end
   end

endmodule

// File: source/exec_stage.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module exec_stage (
   input  logic                  clk,
   input  logic                  if_id_reset,
   input  pipe_pkg::id_ex_t      id_ex,
   input  logic                  flush,
   output pipe_pkg::wb_t         alu_wb,
   output logic                  branch_taken,
   output logic [`ADDR_SIZE-1:0] branch_target
);

   logic [`REG_SIZE-1:0] imm_ext;
   logic [`REG_SIZE-1:0] op2;
   logic [`REG_SIZE-1:0] result;
   logic                 live;

   assign imm_ext = {{(`REG_SIZE-16){id_ex.imm[15]}}, id_ex.imm};
   assign op2     = id_ex.alusrc ? imm_ext : id_ex.src2;
   assign live    = id_ex.valid && !id_ex.is_mult && !flush;  // Multiplies go elsewhere

   always_comb begin
      case (id_ex.alu_op)
         pipe_pkg::ALU_ADD: result = id_ex.src1 + op2;
         pipe_pkg::ALU_SUB: result = id_ex.src1 - op2;
         pipe_pkg::ALU_AND: result = id_ex.src1 & op2;
         pipe_pkg::ALU_OR:  result = id_ex.src1 | op2;
         pipe_pkg::ALU_SLT: result = {{(`REG_SIZE-1){1'b0}}, $signed(id_ex.src1) < $signed(op2)};
         default:           result = '0;
      endcase
   end

   // beq compares the raw register operands
   assign branch_taken  = live && id_ex.is_branch && (id_ex.src1 == id_ex.src2);
   assign branch_target = id_ex.pc + `ADDR_SIZE'(4) + {imm_ext[`ADDR_SIZE-3:0], 2'b00};

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         alu_wb.valid <= 1'b0;
      end else begin
         alu_wb.valid <= live && id_ex.regwrite;  // Branches never set regwrite
      end
   end

   always_ff @(posedge clk) begin
      alu_wb.dst  <= id_ex.dst;
      alu_wb.data <= result;
   end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module fetch_stage (
   input  logic                  clk,
   input  logic                  if_id_reset,
   input  logic                  pc_write,
   input  logic                  branch_taken,
   input  logic [`ADDR_SIZE-1:0] branch_target,
   output logic [`ADDR_SIZE-1:0] pc
);

   logic [`ADDR_SIZE-1:0] pc_next;

   // Redirect wins over sequential fetch
   always_comb begin
      if (branch_taken) begin
         pc_next = branch_target;
      end else begin
         pc_next = pc + `ADDR_SIZE'(4);
      end
   end

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         pc <= '0;
      end else if (pc_write) begin
         pc <= pc_next;
      end
      // Holds when not written
   end

endmodule

// File: source/isa_pkg.sv
`include "cpu_consts.svh"

package isa_pkg;

   // Primary opcodes, MIPS numbering
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_BEQ   = 6'h04,
      OP_ADDI  = 6'h08
   } opcode_t;

   // R-type function field
   typedef enum logic [5:0] {
      FN_MUL = 6'h18,
      FN_ADD = 6'h20,
      FN_SUB = 6'h22,
      FN_AND = 6'h24,
      FN_OR  = 6'h25,
      FN_SLT = 6'h2a
   } funct_t;

   typedef struct packed {
      opcode_t              opcode;
      logic [`REG_ADDR-1:0] rs;
      logic [`REG_ADDR-1:0] rt;
      logic [`REG_ADDR-1:0] rd;     // Destination
      logic [4:0]           shamt;  // Unused by this core
      funct_t               funct;
   } r_fmt_t;

   typedef struct packed {
      opcode_t              opcode;
      logic [`REG_ADDR-1:0] rs;
      logic [`REG_ADDR-1:0] rt;     // Destination for addi
      logic [15:0]          imm;
   } i_fmt_t;

   // One fetched word, read through either view
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

endpackage

// File: source/mult_pipe.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module mult_pipe (
   input  logic                  clk,
   input  logic                  if_id_reset,
   input  pipe_pkg::id_ex_t      id_ex,
   output pipe_pkg::wb_t         mult_wb,
   output logic [`REG_COUNT-1:0] pending_mask
);

   pipe_pkg::wb_t        stg [`MULT_STAGES];
   logic [`REG_SIZE-1:0] product;

   assign product = id_ex.src1 * id_ex.src2;  // Low half only

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         for (int i = 0; i < `MULT_STAGES; i++) begin
            stg[i].valid <= 1'b0;
         end
      end else begin
         stg[0].valid <= id_ex.valid && id_ex.is_mult && id_ex.regwrite;
         for (int i = 1; i < `MULT_STAGES; i++) begin
            stg[i].valid <= stg[i-1].valid;
         end
      end
   end

   always_ff @(posedge clk) begin
      stg[0].dst  <= id_ex.dst;
      stg[0].data <= product;
      for (int i = 1; i < `MULT_STAGES; i++) begin
         stg[i].dst  <= stg[i-1].dst;
         stg[i].data <= stg[i-1].data;
      end
   end

   assign mult_wb = stg[`MULT_STAGES-1];

   // Destinations decode must wait on
   always_comb begin
      pending_mask = '0;
      for (int i = 0; i < `MULT_STAGES; i++) begin
         if (stg[i].valid) begin
            pending_mask[stg[i].dst] = 1'b1;
         end
      end
   end

endmodule

// File: source/pipe_pkg.sv
`include "cpu_consts.svh"

package pipe_pkg;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_t;

   // Decode/execute register
   typedef struct packed {
      logic                  valid;
      logic [`ADDR_SIZE-1:0] pc;
      logic [`REG_SIZE-1:0]  src1;
      logic [`REG_SIZE-1:0]  src2;
      logic [15:0]           imm;       // Raw, extended in exec
      logic [`REG_ADDR-1:0]  dst;
      logic                  regwrite;
      logic                  alusrc;    // Immediate as second operand
      logic                  is_branch;
      logic                  is_mult;
      alu_op_t               alu_op;
   } id_ex_t;

   // One register write
   typedef struct packed {
      logic                 valid;
      logic [`REG_ADDR-1:0] dst;
      logic [`REG_SIZE-1:0] data;
   } wb_t;

   // Per-cycle control of a stage register
   typedef struct packed {
      logic hold;
      logic flush;
   } stage_ctl_t;

endpackage

// File: source/regfile.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module regfile (
   input  logic                 clk,
   input  logic [`REG_ADDR-1:0] rs1,
   input  logic [`REG_ADDR-1:0] rs2,
   input  pipe_pkg::wb_t        wr,
   output logic [`REG_SIZE-1:0] rdata1,
   output logic [`REG_SIZE-1:0] rdata2
);

   logic [`REG_SIZE-1:0] regs [`REG_COUNT];

   // r0 is hardwired and a write in flight is forwarded
   function automatic logic [`REG_SIZE-1:0] read_port(input logic [`REG_ADDR-1:0] addr);
      logic [`REG_SIZE-1:0] data;
      if (addr == '0) begin
         data = '0;
      end else if (wr.valid && wr.dst == addr) begin
         data = wr.data;
      end else begin
         data = regs[addr];
      end
      return data;
   endfunction

   always_ff @(posedge clk) begin
      if (wr.valid && wr.dst != '0) begin
         regs[wr.dst] <= wr.data;
      end
   end

   always_comb begin
      rdata1 = read_port(rs1);
      rdata2 = read_port(rs2);
   end

endmodule

// File: verification/cpu_properties.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module cpu_properties (
   input logic                  clk,
   input logic                  if_id_reset,
   input logic [`ADDR_SIZE-1:0] imem_addr,
   input pipe_pkg::wb_t         wb,
   input pipe_pkg::wb_t         alu_wb,
   input pipe_pkg::wb_t         mult_wb,
   input logic                  branch_taken,
   input logic [`ADDR_SIZE-1:0] branch_target
);

   // Write-back register comes out of reset empty
   wb_idle_after_reset: assert property (@(posedge clk) if_id_reset |=> !wb.valid)
      else $error("write-back valid in the cycle after reset");

   // Decode keeps the two result paths apart
   one_result_source: assert property (@(posedge clk) disable iff (if_id_reset)
      !(alu_wb.valid && mult_wb.valid))
      else $error("ALU and multiply results valid in the same cycle");

   no_r0_write: assert property (@(posedge clk) disable iff (if_id_reset)
      wb.valid |-> wb.dst != '0)
      else $error("write-back record targets r0");

   // Redirect lands on the next fetch address
   branch_redirect: assert property (@(posedge clk) disable iff (if_id_reset)
      branch_taken |=> imem_addr == $past(branch_target))
      else $error("fetch address does not follow a taken branch");

endmodule

bind cpu cpu_properties cpu_properties_inst (
   .clk          (clk),
   .if_id_reset  (if_id_reset),
   .imem_addr    (imem_addr),
   .wb           (wb),
   .alu_wb       (alu_wb),
   .mult_wb      (mult_wb),
   .branch_taken (branch_taken),
   .branch_target(branch_target)
);

// File: verification/cpu_tb.sv
`timescale 1ns/1ps

`include "cpu_consts.svh"

module cpu_tb;

   localparam int CLK_HALF        = 10;
   localparam int DRIVE_DELAY     = 2;
   localparam int RESET_CYCLES    = 3;
   localparam int DATA_DEPTH      = 128;
   localparam int PROG_DEPTH      = 64;
   localparam int ENTRY_BITS      = 44;
   localparam int TAIL_CYCLES     = 20;
   localparam int CYCLES_PER_WORD = 40;
   localparam int CYCLE_MARGIN    = 100;

   logic                  clk;
   logic                  if_id_reset;
   logic [`ADDR_SIZE-1:0] imem_addr;
   isa_pkg::instr_u       imem_data;
   logic                  imem_valid;
   pipe_pkg::wb_t         wb;

   logic [ENTRY_BITS-1:0] testdata [DATA_DEPTH];
   isa_pkg::instr_u       program_mem [PROG_DEPTH];
   pipe_pkg::wb_t         expected_q [$];
   int                    prog_words;
   int                    record_count;
   int                    cycle_count;
   int                    cycle_limit;
   integer                seed;

   cpu cpu_inst (
      .clk        (clk),
      .if_id_reset(if_id_reset),
      .imem_addr  (imem_addr),
      .imem_data  (imem_data),
      .imem_valid (imem_valid),
      .wb         (wb)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   task automatic abort_run();
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_wb(input string name, input pipe_pkg::wb_t expected,
                           input pipe_pkg::wb_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected valid %b r%0d = %h, actual valid %b r%0d = %h",
                  name, expected.valid, expected.dst, expected.data,
                  actual.valid, actual.dst, actual.data);
         abort_run();
      end
   endtask

   task automatic check_pc(input string name, input logic [`ADDR_SIZE-1:0] expected,
                           input logic [`ADDR_SIZE-1:0] actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
         abort_run();
      end
   endtask

   // Splits the file into program words and expected records
   task automatic load_testdata();
      logic [ENTRY_BITS-1:0] entry;
      pipe_pkg::wb_t         rec;
      prog_words = 0;
      for (int i = 0; i < DATA_DEPTH; i++) begin
         testdata[i] = '0;
      end
      for (int i = 0; i < PROG_DEPTH; i++) begin
         program_mem[i] = '0;  // Zero word is a bubble
      end
      $readmemh("verification/cpu_testdata.txt", testdata);
      for (int i = 0; i < DATA_DEPTH; i++) begin
         entry = testdata[i];
         case (entry[ENTRY_BITS-1 -: 4])
            4'h1: begin
               program_mem[prog_words] = entry[`REG_SIZE-1:0];
               prog_words++;
            end
            4'h2: begin
               rec.valid = 1'b1;
               rec.dst   = entry[`REG_SIZE +: `REG_ADDR];
               rec.data  = entry[`REG_SIZE-1:0];
               expected_q.push_back(rec);
            end
            default: ;
         endcase
      end
      cycle_limit = CYCLES_PER_WORD * prog_words + CYCLE_MARGIN;
   endtask

   // Past the program end the memory returns bubbles
   function automatic isa_pkg::instr_u fetch_word(input logic [`ADDR_SIZE-1:0] addr);
      logic [`ADDR_SIZE-1:0] index;
      isa_pkg::instr_u       word;
      index = addr >> 2;
      word  = '0;
      if (index < PROG_DEPTH) begin
         word = program_mem[index];
      end
      return word;
   endfunction

   always @(posedge clk) begin
      #DRIVE_DELAY;
      imem_data  = fetch_word(imem_addr);
      imem_valid = ($random(seed) & 3) != 0;  // Gap on about one cycle in four
   end

   task automatic compare_next_record();
      pipe_pkg::wb_t expected;
      if (expected_q.size() == 0) begin
         $display("Unexpected write-back to r%0d after the last expected record", wb.dst);
         abort_run();
      end else begin
         expected = expected_q.pop_front();
         check_wb($sformatf("wb record %0d", record_count), expected, wb);
         record_count++;
      end
   endtask

   always @(negedge clk) begin
      if (!if_id_reset && wb.valid === 1'b1) begin
         compare_next_record();
      end
   end

   always @(negedge clk) begin
      if (!if_id_reset) begin
         cycle_count++;
         if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d write-back records still missing",
                     cycle_count, expected_q.size());
            abort_run();
         end
      end
   end

   initial begin
      seed         = 87;
      if_id_reset  = 1'b1;
      imem_data    = '0;
      imem_valid   = 1'b0;
      record_count = 0;
      cycle_count  = 0;
      load_testdata();
      if (expected_q.size() == 0) begin
         $display("Test data holds no expected write-back records");
         abort_run();
      end else begin
         repeat (RESET_CYCLES) @(posedge clk);
         #DRIVE_DELAY;
         if_id_reset = 1'b0;
         check_pc("fetch address after reset", '0, imem_addr);
         check_bit("write-back idle after reset", 1'b0, wb.valid);
         while (expected_q.size() != 0) begin
            @(posedge clk);
         end
         repeat (TAIL_CYCLES) @(posedge clk);  // Catches a late stray write
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

// File: verification/cpu_testdata.txt
// Entry is kind_dst_data in hex. Kind 1 is the next program word, kind 2 an expected write.
// A line holds one program word and then the write it must produce, if any.
1_00_20010005  2_01_00000005  // addi r1, r0, 5
1_00_20020003  2_02_00000003  // addi r2, r0, 3
1_00_2003FFFE  2_03_FFFFFFFE  // addi r3, r0, -2
1_00_00222020  2_04_00000008  // add r4, r1, r2
1_00_00222822  2_05_00000002  // sub r5, r1, r2
1_00_00223024  2_06_00000001  // and r6, r1, r2
1_00_00223825  2_07_00000007  // or r7, r1, r2
1_00_0061402A  2_08_00000001  // slt r8, r3, r1
1_00_0023482A  2_09_00000000  // slt r9, r1, r3
1_00_00225018  2_0A_0000000F  // mul r10, r1, r2
1_00_00615818  2_0B_FFFFFFF6  // mul r11, r3, r1
1_00_00876018  2_0C_00000038  // mul r12, r4, r7
1_00_200D7FFF  2_0D_00007FFF  // addi r13, r0, 0x7fff waits for the multiplies
1_00_01AD7018  2_0E_3FFF0001  // mul r14, r13, r13
1_00_01CE7818  2_0F_7FFE0001  // mul r15, r14, r14 keeps the low word
1_00_01EA8020  2_10_7FFE0010  // add r16, r15, r10
1_00_10220002                 // beq r1, r2, +2 not taken
1_00_20110011  2_11_00000011  // addi r17, r0, 0x11
1_00_22320001  2_12_00000012  // addi r18, r17, 1
1_00_10A50002                 // beq r5, r5, +2 taken
1_00_20130099                 // addi r19, r0, 0x99 skipped
1_00_20140098                 // addi r20, r0, 0x98 skipped
1_00_22550100  2_15_00000112  // addi r21, r18, 0x100
1_00_0055B022  2_16_FFFFFEF1  // sub r22, r2, r21
1_00_10000002                 // beq r0, r0, +2 taken
1_00_0021B820                 // add r23, r1, r1 skipped
1_00_0021C018                 // mul r24, r1, r1 skipped
1_00_02C1C820  2_19_FFFFFEF6  // add r25, r22, r1
1_00_20200007                 // addi r0, r1, 7 writes nothing
